//--- Makefile
# Verilator build for the configuration control unit

VERILATOR   ?= verilator
TOP         ?= ccu_tb
FLIST       ?= ccu.f
BUILD_DIR   ?= obj_dir
LOG         ?= sim.log
VFLAGS      ?= --binary --timing -Wno-fatal
PASS_STRING ?= Result: PASSED

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "$(PASS_STRING)" $(LOG) || (echo "Simulation did not pass" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- ccu.f
+incdir+testbench
logic/ccu_pkg.sv
logic/ccu_ctrl_fsm.sv
logic/isa_fetch.sv
logic/isa_decoder.sv
logic/cfg_slot.sv
logic/ccu_top.sv
testbench/ccu_tb.sv

//--- logic/ccu_ctrl_fsm.sv
module ccu_ctrl_fsm (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start_i,
    input  logic [2:0]        mdu_rdy_i,     // SYA, KNN, FPS
    input  logic              ccu_done_i,
    input  logic [2:0]        cfg_taken_i,
    input  ccu_pkg::ccu_cfg_t ccu_cfg_i,
    output ccu_pkg::mdu_idx_t sel_o,
    output logic              fetch_en_o,
    output logic              net_fnh_o,
    output logic              mdu_rst_o
);

    ccu_pkg::ctrl_state_t state_q, state_d;
    ccu_pkg::mdu_idx_t    sel_q, pick;
    logic                 self_rdy_q;
    logic [ccu_pkg::NUM_MDU-1:0] req, taken_all;
    logic [ccu_pkg::NLY_W-1:0]   sya_cnt_q;
    logic                 cfg_done, sya_done, layer_hit;

    assign req       = {mdu_rdy_i, self_rdy_q};   // Index 0 is the CCU itself
    assign taken_all = {cfg_taken_i, ccu_done_i};
    assign cfg_done  = taken_all[sel_q];
    assign sya_done  = state_q == ccu_pkg::CFG && sel_q == ccu_pkg::MDU_SYA && cfg_taken_i[2];
    assign layer_hit = (sya_cnt_q + 1'b1) == ccu_cfg_i.num_ly && ccu_cfg_i.num_ly != '0;

    // Lowest requesting index wins
    always_comb begin
        pick = ccu_pkg::MDU_CCU;
        for (int i = ccu_pkg::NUM_MDU - 1; i >= 0; i--) begin
            if (req[i]) begin
                pick = ccu_pkg::mdu_idx_t'(i);
            end
        end
    end

    // ======================================================================
    // State machine
    // ======================================================================
    always_comb begin
        state_d = state_q;
        case (state_q)
            ccu_pkg::IDLE: begin
                if (start_i) begin
                    state_d = ccu_pkg::IDLE_CFG;
                end
            end
            ccu_pkg::IDLE_CFG: begin
                if (|req) begin
                    state_d = ccu_pkg::CFG;
                end
            end
            ccu_pkg::CFG: begin
                if (cfg_done) begin
                    state_d = (sya_done && layer_hit) ? ccu_pkg::NETFNH : ccu_pkg::IDLE_CFG;
                end
            end
            default: state_d = ccu_pkg::IDLE;   // NETFNH lasts one cycle
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q    <= ccu_pkg::IDLE;
            sel_q      <= ccu_pkg::MDU_CCU;
            self_rdy_q <= 1'b1;
            sya_cnt_q  <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == ccu_pkg::IDLE_CFG && |req) begin
                sel_q <= pick;              // Held for the whole CFG state
            end
            if (state_q == ccu_pkg::IDLE) begin
                self_rdy_q <= 1'b1;
            end else if (ccu_done_i) begin
                self_rdy_q <= 1'b0;
            end
            if (state_q == ccu_pkg::IDLE) begin
                sya_cnt_q <= '0;
            end else if (sya_done) begin
                sya_cnt_q <= sya_cnt_q + 1'b1;  // One per accepted layer
            end
        end
    end

    assign sel_o      = sel_q;
    assign fetch_en_o = state_q == ccu_pkg::CFG;
    assign net_fnh_o  = state_q == ccu_pkg::NETFNH;
    assign mdu_rst_o  = state_q == ccu_pkg::IDLE;

endmodule

//--- logic/ccu_pkg.sv
package ccu_pkg;

    // ======================================================================
    // Widths
    // ======================================================================
    localparam int ADDR_W  = 16;
    localparam int ISA_W   = 256;
    localparam int OP_W    = 8;
    localparam int NUM_MDU = 4;    // CCU itself plus FPS, KNN, SYA
    localparam int NUM_FPC = 4;    // FPS cores
    localparam int IDX_W   = 16;   // Point index
    localparam int CHN_W   = 12;
    localparam int QNTSL_W = 20;
    localparam int ACT_W   = 8;
    localparam int MAP_W   = 5;
    localparam int NLY_W   = 20;
    localparam int MODE_W  = 8;

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [ISA_W-1:0]  isa_word_t;
    typedef logic [OP_W-1:0]   opcode_t;
    typedef logic [1:0]        mdu_idx_t;

    // Module index doubles as the opcode in bits 7:0
    localparam mdu_idx_t MDU_CCU = 2'd0;
    localparam mdu_idx_t MDU_FPS = 2'd1;
    localparam mdu_idx_t MDU_KNN = 2'd2;
    localparam mdu_idx_t MDU_SYA = 2'd3;

    // Words per instruction for each opcode
    localparam logic [NUM_MDU-1:0][1:0] WORDS_PER_OP = {2'd1, 2'd1, 2'd3, 2'd1};

    // ======================================================================
    // Configuration payloads
    // ======================================================================
    typedef struct packed {
        logic [NLY_W-1:0]  num_ly;
        logic [MODE_W-1:0] mode;
    } ccu_cfg_t;

    typedef logic [NUM_FPC-1:0][IDX_W-1:0] fpc_vec_t;   // One field for every core

    typedef struct packed {
        fpc_vec_t nip;
        fpc_vec_t nop;
        fpc_vec_t crd_rd_base;
        fpc_vec_t crd_wr_base;
        fpc_vec_t idx_wr_base;
        fpc_vec_t msk_base;
        fpc_vec_t dst_base;
    } fps_cfg_t;

    typedef struct packed {
        logic [IDX_W-1:0] nip;
        logic [MAP_W:0]   k;
        addr_t            crd_rd_addr;
        addr_t            map_wr_addr;
    } knn_cfg_t;

    typedef struct packed {
        logic [1:0]         mode;
        logic [IDX_W-1:0]   nip;
        logic [CHN_W-1:0]   chi;
        logic [QNTSL_W-1:0] scale;
        logic [ACT_W-1:0]   shift;
        logic [ACT_W-1:0]   zp;
        addr_t              act_base;
        addr_t              wgt_base;
        addr_t              ofm_base;
    } sya_cfg_t;

    // One matched instruction word
    typedef struct packed {
        mdu_idx_t   idx;
        logic [1:0] wrd;    // Word number within the instruction
        logic       last;
        isa_word_t  dat;
    } isa_beat_t;

    typedef enum logic [1:0] {
        IDLE,
        IDLE_CFG,
        CFG,
        NETFNH
    } ctrl_state_t;

endpackage

//--- logic/ccu_top.sv
module ccu_top #(
    parameter ccu_pkg::addr_t ISA_START_ADDR = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               start_i,
    output logic               net_fnh_o,
    output logic               mdu_rst_o,
    // Instruction buffer read
    output ccu_pkg::addr_t     isa_rd_addr_o,
    output logic               isa_rd_addr_vld_o,
    input  logic               isa_rd_addr_rdy_i,
    input  ccu_pkg::isa_word_t isa_rd_dat_i,
    input  logic               isa_rd_dat_vld_i,
    output logic               isa_rd_dat_rdy_o,
    output ccu_pkg::addr_t     rd_addr_min_o,   // Loader must stay below this
    // Module configuration ports
    output logic               fps_cfg_vld_o,
    input  logic               fps_cfg_rdy_i,
    output ccu_pkg::fps_cfg_t  fps_cfg_o,
    output logic               knn_cfg_vld_o,
    input  logic               knn_cfg_rdy_i,
    output ccu_pkg::knn_cfg_t  knn_cfg_o,
    output logic               sya_cfg_vld_o,
    input  logic               sya_cfg_rdy_i,
    output ccu_pkg::sya_cfg_t  sya_cfg_o
);

    ccu_pkg::mdu_idx_t  sel;
    ccu_pkg::isa_beat_t beat;
    ccu_pkg::ccu_cfg_t  ccu_cfg;
    ccu_pkg::fps_cfg_t  fps_pld;
    ccu_pkg::knn_cfg_t  knn_pld;
    ccu_pkg::sya_cfg_t  sya_pld;
    logic               fetch_en, beat_vld, ccu_done;
    logic               fps_ld, knn_ld, sya_ld;
    logic [2:0]         taken;

    // ======================================================================
    // Control and fetch
    // ======================================================================
    ccu_ctrl_fsm ccu_ctrl_fsm_inst (
        .clk         (clk),
        .rst_n       (rst_n),
        .start_i     (start_i),
        .mdu_rdy_i   ({sya_cfg_rdy_i, knn_cfg_rdy_i, fps_cfg_rdy_i}),
        .ccu_done_i  (ccu_done),
        .cfg_taken_i (taken),
        .ccu_cfg_i   (ccu_cfg),
        .sel_o       (sel),
        .fetch_en_o  (fetch_en),
        .net_fnh_o   (net_fnh_o),
        .mdu_rst_o   (mdu_rst_o)
    );

    isa_fetch #(
        .ISA_START_ADDR (ISA_START_ADDR)
    ) isa_fetch_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .clr_i             (mdu_rst_o),
        .fetch_en_i        (fetch_en),
        .sel_i             (sel),
        .isa_rd_addr_o     (isa_rd_addr_o),
        .isa_rd_addr_vld_o (isa_rd_addr_vld_o),
        .isa_rd_addr_rdy_i (isa_rd_addr_rdy_i),
        .isa_rd_dat_i      (isa_rd_dat_i),
        .isa_rd_dat_vld_i  (isa_rd_dat_vld_i),
        .isa_rd_dat_rdy_o  (isa_rd_dat_rdy_o),
        .beat_o            (beat),
        .beat_vld_o        (beat_vld),
        .ccu_done_o        (ccu_done),
        .rd_addr_min_o     (rd_addr_min_o)
    );

    isa_decoder isa_decoder_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .beat_i     (beat),
        .beat_vld_i (beat_vld),
        .ccu_cfg_o  (ccu_cfg),
        .fps_ld_o   (fps_ld),
        .fps_cfg_o  (fps_pld),
        .knn_ld_o   (knn_ld),
        .knn_cfg_o  (knn_pld),
        .sya_ld_o   (sya_ld),
        .sya_cfg_o  (sya_pld)
    );

    // ======================================================================
    // Held configurations
    // ======================================================================
    cfg_slot #(.payload_t(ccu_pkg::fps_cfg_t)) fps_slot_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_i      (fps_ld),
        .payload_i (fps_pld),
        .cfg_vld_o (fps_cfg_vld_o),
        .cfg_o     (fps_cfg_o),
        .taken_o   (taken[0]),
        .cfg_rdy_i (fps_cfg_rdy_i)
    );

    cfg_slot #(.payload_t(ccu_pkg::knn_cfg_t)) knn_slot_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_i      (knn_ld),
        .payload_i (knn_pld),
        .cfg_vld_o (knn_cfg_vld_o),
        .cfg_o     (knn_cfg_o),
        .taken_o   (taken[1]),
        .cfg_rdy_i (knn_cfg_rdy_i)
    );

    cfg_slot #(.payload_t(ccu_pkg::sya_cfg_t)) sya_slot_inst (
        .clk       (clk),
        .rst_n     (rst_n),
        .ld_i      (sya_ld),
        .payload_i (sya_pld),
        .cfg_vld_o (sya_cfg_vld_o),
        .cfg_o     (sya_cfg_o),
        .taken_o   (taken[2]),
        .cfg_rdy_i (sya_cfg_rdy_i)
    );

endmodule

//--- logic/cfg_slot.sv
module cfg_slot #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     ld_i,
    input  payload_t payload_i,
    output logic     cfg_vld_o,
    output payload_t cfg_o,
    output logic     taken_o,
    input  logic     cfg_rdy_i
);

    assign taken_o = cfg_vld_o && cfg_rdy_i;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cfg_vld_o <= 1'b0;
        end else if (ld_i) begin
            cfg_vld_o <= 1'b1;
        end else if (taken_o) begin
            cfg_vld_o <= 1'b0;      // Handshake with the module
        end
    end

    always_ff @(posedge clk) begin
        if (ld_i) begin
            cfg_o <= payload_i;
        end
    end

endmodule

//--- logic/isa_decoder.sv
module isa_decoder (
    input  logic               clk,
    input  logic               rst_n,
    input  ccu_pkg::isa_beat_t beat_i,
    input  logic               beat_vld_i,
    output ccu_pkg::ccu_cfg_t  ccu_cfg_o,
    output logic               fps_ld_o,
    output ccu_pkg::fps_cfg_t  fps_cfg_o,
    output logic               knn_ld_o,
    output ccu_pkg::knn_cfg_t  knn_cfg_o,
    output logic               sya_ld_o,
    output ccu_pkg::sya_cfg_t  sya_cfg_o
);

    localparam int OP_W  = ccu_pkg::OP_W;
    localparam int GRP_W = ccu_pkg::NUM_FPC * ccu_pkg::IDX_W;   // One FPS field over all cores
    localparam int IDX_W = ccu_pkg::IDX_W;
    // SYA mode sits in an 8-bit slot after the opcode
    localparam int SYA_NIP = 2 * OP_W;
    localparam int SYA_CHI = SYA_NIP + IDX_W;
    localparam int SYA_SCL = SYA_CHI + ccu_pkg::CHN_W;
    localparam int SYA_SFT = SYA_SCL + ccu_pkg::QNTSL_W;
    localparam int SYA_ZP  = SYA_SFT + ccu_pkg::ACT_W;
    localparam int SYA_ACT = SYA_ZP + ccu_pkg::ACT_W;

    ccu_pkg::isa_word_t  dat;
    logic                fps_hit;
    logic [3*GRP_W-1:0]  fps_w0_q, fps_w1_q;

    assign dat     = beat_i.dat;
    assign fps_hit = beat_vld_i && beat_i.idx == ccu_pkg::MDU_FPS;

    // ======================================================================
    // FPS staging of words 1 and 2
    // ======================================================================
    always_ff @(posedge clk) begin
        if (fps_hit && beat_i.wrd == 2'd0) begin
            fps_w0_q <= dat[OP_W +: 3*GRP_W];
        end
        if (fps_hit && beat_i.wrd == 2'd1) begin
            fps_w1_q <= dat[OP_W +: 3*GRP_W];
        end
    end

    always_comb begin
        fps_cfg_o.nip         = fps_w0_q[0       +: GRP_W];
        fps_cfg_o.nop         = fps_w0_q[GRP_W   +: GRP_W];
        fps_cfg_o.crd_rd_base = fps_w0_q[2*GRP_W +: GRP_W];
        fps_cfg_o.crd_wr_base = fps_w1_q[0       +: GRP_W];
        fps_cfg_o.idx_wr_base = fps_w1_q[GRP_W   +: GRP_W];
        fps_cfg_o.msk_base    = fps_w1_q[2*GRP_W +: GRP_W];
        fps_cfg_o.dst_base    = dat[OP_W +: GRP_W];       // Straight from word 3
    end

    // Single-word payloads keep each field in a 16-bit slot
    always_comb begin
        knn_cfg_o.nip         = dat[OP_W           +: IDX_W];
        knn_cfg_o.k           = dat[OP_W + IDX_W   +: ccu_pkg::MAP_W + 1];
        knn_cfg_o.crd_rd_addr = dat[OP_W + 2*IDX_W +: ccu_pkg::ADDR_W];
        knn_cfg_o.map_wr_addr = dat[OP_W + 3*IDX_W +: ccu_pkg::ADDR_W];

        sya_cfg_o.mode     = dat[OP_W    +: 2];
        sya_cfg_o.nip      = dat[SYA_NIP +: IDX_W];
        sya_cfg_o.chi      = dat[SYA_CHI +: ccu_pkg::CHN_W];
        sya_cfg_o.scale    = dat[SYA_SCL +: ccu_pkg::QNTSL_W];
        sya_cfg_o.shift    = dat[SYA_SFT +: ccu_pkg::ACT_W];
        sya_cfg_o.zp       = dat[SYA_ZP  +: ccu_pkg::ACT_W];
        sya_cfg_o.act_base = dat[SYA_ACT                        +: ccu_pkg::ADDR_W];
        sya_cfg_o.wgt_base = dat[SYA_ACT + ccu_pkg::ADDR_W      +: ccu_pkg::ADDR_W];
        sya_cfg_o.ofm_base = dat[SYA_ACT + 2 * ccu_pkg::ADDR_W  +: ccu_pkg::ADDR_W];
    end

    assign fps_ld_o = fps_hit && beat_i.last;
    assign knn_ld_o = beat_vld_i && beat_i.last && beat_i.idx == ccu_pkg::MDU_KNN;
    assign sya_ld_o = beat_vld_i && beat_i.last && beat_i.idx == ccu_pkg::MDU_SYA;

    // Own configuration with the layer count above the mode
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            ccu_cfg_o <= '0;
        end else if (beat_vld_i && beat_i.last && beat_i.idx == ccu_pkg::MDU_CCU) begin
            ccu_cfg_o <= dat[OP_W +: $bits(ccu_pkg::ccu_cfg_t)];
        end
    end

endmodule

//--- logic/isa_fetch.sv
module isa_fetch #(
    parameter ccu_pkg::addr_t ISA_START_ADDR = '0
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               clr_i,        // Held in IDLE
    input  logic               fetch_en_i,
    input  ccu_pkg::mdu_idx_t  sel_i,
    output ccu_pkg::addr_t     isa_rd_addr_o,
    output logic               isa_rd_addr_vld_o,
    input  logic               isa_rd_addr_rdy_i,
    input  ccu_pkg::isa_word_t isa_rd_dat_i,
    input  logic               isa_rd_dat_vld_i,
    output logic               isa_rd_dat_rdy_o,
    output ccu_pkg::isa_beat_t beat_o,
    output logic               beat_vld_o,
    output logic               ccu_done_o,
    output ccu_pkg::addr_t     rd_addr_min_o
);

    ccu_pkg::addr_t rd_ptr_q [ccu_pkg::NUM_MDU];
    logic           pend_q;     // One word in flight
    logic           done_q;     // Last word of the instruction seen
    logic [1:0]     wcnt_q;
    logic           addr_hs, dat_hs, match, last;

    assign isa_rd_addr_vld_o = fetch_en_i && !pend_q && !done_q;
    assign isa_rd_addr_o     = rd_ptr_q[sel_i];
    assign isa_rd_dat_rdy_o  = pend_q;

    assign addr_hs = isa_rd_addr_vld_o && isa_rd_addr_rdy_i;
    assign dat_hs  = isa_rd_dat_vld_i && pend_q;
    assign match   = dat_hs && isa_rd_dat_i[ccu_pkg::OP_W-1:0] == ccu_pkg::opcode_t'(sel_i);
    assign last    = (wcnt_q + 2'd1) == ccu_pkg::WORDS_PER_OP[sel_i];

    // ======================================================================
    // One read pointer per module
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < ccu_pkg::NUM_MDU; i++) begin
                rd_ptr_q[i] <= ISA_START_ADDR;
            end
        end else if (clr_i) begin
            for (int i = 0; i < ccu_pkg::NUM_MDU; i++) begin
                rd_ptr_q[i] <= ISA_START_ADDR;
            end
        end else if (addr_hs) begin
            rd_ptr_q[sel_i] <= rd_ptr_q[sel_i] + 1'b1;  // Skipped words count too
        end
    end

    always_comb begin
        rd_addr_min_o = rd_ptr_q[0];
        for (int i = 1; i < ccu_pkg::NUM_MDU; i++) begin
            if (rd_ptr_q[i] < rd_addr_min_o) begin
                rd_addr_min_o = rd_ptr_q[i];
            end
        end
    end

    // ======================================================================
    // Word handshake and counter
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pend_q <= 1'b0;
            done_q <= 1'b0;
            wcnt_q <= '0;
        end else begin
            if (addr_hs) begin
                pend_q <= 1'b1;
            end else if (dat_hs) begin
                pend_q <= 1'b0;
            end
            if (!fetch_en_i) begin
                done_q <= 1'b0;     // Rearmed by the next choice
                wcnt_q <= '0;
            end else if (match) begin
                done_q <= last;
                wcnt_q <= last ? 2'd0 : wcnt_q + 2'd1;
            end
        end
    end

    assign beat_vld_o  = match;
    assign beat_o.idx  = sel_i;
    assign beat_o.wrd  = wcnt_q;
    assign beat_o.last = last;
    assign beat_o.dat  = isa_rd_dat_i;
    assign ccu_done_o  = match && last && sel_i == ccu_pkg::MDU_CCU;

endmodule

//--- testbench/ccu_tb_isa.svh
`ifndef CCU_TB_ISA_SVH
`define CCU_TB_ISA_SVH

// Value of one FPS field for one core
function automatic logic [15:0] fps_core_val(input int i, input int k, input int c);
    return tbl_v[i][k][15:0] + 16'(c);
endfunction

function automatic int words_of(input int op);
    return (op == 1) ? 3 : 1;
endfunction

// Packs table entry i into the buffer starting at word pos
task automatic put_entry(input int pos, input int i);
    ccu_pkg::isa_word_t w;
    int                 k;
    case (tbl_op[i])
        0: begin
            w = '0;
            w[15:8]  = tbl_v[i][1][7:0];     // Mode
            w[35:16] = tbl_v[i][0][19:0];    // Layer count
            mem[pos] = w;
        end
        1: begin
            for (int wi = 0; wi < 3; wi++) begin
                w = '0;
                w[7:0] = 8'd1;
                for (int s = 0; s < 3; s++) begin
                    k = 3 * wi + s;
                    for (int c = 0; c < 4; c++) begin
                        if (k < 7) w[8 + s*64 + c*16 +: 16] = fps_core_val(i, k, c);
                    end
                end
                mem[pos + wi] = w;
            end
        end
        2: begin
            w = '0;
            w[7:0]   = 8'd2;
            w[8 +: 16]  = tbl_v[i][0][15:0];
            w[24 +: 6]  = tbl_v[i][1][5:0];
            w[40 +: 16] = tbl_v[i][2][15:0];
            w[56 +: 16] = tbl_v[i][3][15:0];
            mem[pos] = w;
        end
        default: begin
            w = '0;
            w[7:0]    = 8'd3;
            w[8 +: 2]    = tbl_v[i][0][1:0];
            w[16 +: 16]  = tbl_v[i][1][15:0];
            w[32 +: 12]  = tbl_v[i][2][11:0];
            w[44 +: 20]  = tbl_v[i][3][19:0];
            w[64 +: 8]   = tbl_v[i][4][7:0];
            w[72 +: 8]   = tbl_v[i][5][7:0];
            w[80 +: 16]  = tbl_v[i][6][15:0];
            w[96 +: 16]  = tbl_v[i][7][15:0];
            w[112 +: 16] = tbl_v[i][8][15:0];
            mem[pos] = w;
        end
    endcase
endtask

`endif

//--- testbench/ccu_tb.sv
module ccu_tb;

    localparam ccu_pkg::addr_t START = 16'h0040;
    localparam int NUM_ENT = 8;
    localparam int DEPTH   = 32;

    logic               clk, rst_n, start_i, net_fnh, mdu_rst;
    ccu_pkg::addr_t     rd_addr, rd_addr_min;
    logic               rd_addr_vld, rd_addr_rdy, rd_dat_vld, rd_dat_rdy;
    ccu_pkg::isa_word_t rd_dat;
    logic               fps_vld, fps_rdy, knn_vld, knn_rdy, sya_vld, sya_rdy;
    ccu_pkg::fps_cfg_t  fps_cfg, p_fps_cfg;
    ccu_pkg::knn_cfg_t  knn_cfg, p_knn_cfg;
    ccu_pkg::sya_cfg_t  sya_cfg, p_sya_cfg;

    logic [1:0]         tbl_op [NUM_ENT];
    logic [31:0]        tbl_v [NUM_ENT][9];
    ccu_pkg::isa_word_t mem [DEPTH];
    int                 ord [NUM_ENT];
    int                 idx_of [4][8];
    int                 n_exp [4];
    int                 cnt [4];
    int                 end_pos [4];
    int                 fnh_cnt, cycles, limit;
    ccu_pkg::addr_t     exp_min, a_s, buf_addr;
    logic               run, a_hs_s, d_hs_s, busy, sya_fin, p_fnh;
    logic               p_fps_vld, p_fps_rdy, p_knn_vld, p_knn_rdy, p_sya_vld, p_sya_rdy;
    int                 wait_cnt;

    `include "ccu_tb_isa.svh"

    ccu_top #(.ISA_START_ADDR(START)) ccu_top_inst (
        .clk               (clk),
        .rst_n             (rst_n),
        .start_i           (start_i),
        .net_fnh_o         (net_fnh),
        .mdu_rst_o         (mdu_rst),
        .isa_rd_addr_o     (rd_addr),
        .isa_rd_addr_vld_o (rd_addr_vld),
        .isa_rd_addr_rdy_i (rd_addr_rdy),
        .isa_rd_dat_i      (rd_dat),
        .isa_rd_dat_vld_i  (rd_dat_vld),
        .isa_rd_dat_rdy_o  (rd_dat_rdy),
        .rd_addr_min_o     (rd_addr_min),
        .fps_cfg_vld_o     (fps_vld),
        .fps_cfg_rdy_i     (fps_rdy),
        .fps_cfg_o         (fps_cfg),
        .knn_cfg_vld_o     (knn_vld),
        .knn_cfg_rdy_i     (knn_rdy),
        .knn_cfg_o         (knn_cfg),
        .sya_cfg_vld_o     (sya_vld),
        .sya_cfg_rdy_i     (sya_rdy),
        .sya_cfg_o         (sya_cfg)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic report_error(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "Stopping on first error");
    endtask

    // ======================================================================
    // Instruction table and expected payloads
    // ======================================================================
    task automatic fill_table();
        tbl_op[0] = 2'd0;
        tbl_v[0]  = '{2, 'h5a, 0, 0, 0, 0, 0, 0, 0};    // Two layers
        tbl_op[1] = 2'd1;
        tbl_v[1]  = '{'h1000, 'h1100, 'h1200, 'h1300, 'h1400, 'h1500, 'h1600, 0, 0};
        tbl_op[2] = 2'd2;
        tbl_v[2]  = '{'h0200, 16, 'h3000, 'h3400, 0, 0, 0, 0, 0};
        tbl_op[3] = 2'd3;
        tbl_v[3]  = '{1, 'h0100, 'h040, 'h12345, 'h07, 'h80, 'h5000, 'h6000, 'h7000};
        tbl_op[4] = 2'd1;
        tbl_v[4]  = '{'h2010, 'h2120, 'h2230, 'h2340, 'h2450, 'h2560, 'h2670, 0, 0};
        tbl_op[5] = 2'd2;
        tbl_v[5]  = '{'h0180, 32, 'h3100, 'h3500, 0, 0, 0, 0, 0};
        tbl_op[6] = 2'd2;
        tbl_v[6]  = '{'h0090, 8, 'h3200, 'h3600, 0, 0, 0, 0, 0};
        tbl_op[7] = 2'd3;
        tbl_v[7]  = '{2, 'h0080, 'h0c0, 'h0abcd, 'h05, 'h7f, 'h5100, 'h6100, 'h7100};
    endtask

    function automatic ccu_pkg::fps_cfg_t exp_fps(input int i);
        ccu_pkg::fps_cfg_t r;
        for (int c = 0; c < 4; c++) begin
            r.nip[c]         = fps_core_val(i, 0, c);
            r.nop[c]         = fps_core_val(i, 1, c);
            r.crd_rd_base[c] = fps_core_val(i, 2, c);
            r.crd_wr_base[c] = fps_core_val(i, 3, c);
            r.idx_wr_base[c] = fps_core_val(i, 4, c);
            r.msk_base[c]    = fps_core_val(i, 5, c);
            r.dst_base[c]    = fps_core_val(i, 6, c);
        end
        return r;
    endfunction

    function automatic ccu_pkg::knn_cfg_t exp_knn(input int i);
        ccu_pkg::knn_cfg_t r;
        r.nip         = tbl_v[i][0][15:0];
        r.k           = tbl_v[i][1][5:0];
        r.crd_rd_addr = tbl_v[i][2][15:0];
        r.map_wr_addr = tbl_v[i][3][15:0];
        return r;
    endfunction

    function automatic ccu_pkg::sya_cfg_t exp_sya(input int i);
        ccu_pkg::sya_cfg_t r;
        r.mode     = tbl_v[i][0][1:0];
        r.nip      = tbl_v[i][1][15:0];
        r.chi      = tbl_v[i][2][11:0];
        r.scale    = tbl_v[i][3][19:0];
        r.shift    = tbl_v[i][4][7:0];
        r.zp       = tbl_v[i][5][7:0];
        r.act_base = tbl_v[i][6][15:0];
        r.wgt_base = tbl_v[i][7][15:0];
        r.ofm_base = tbl_v[i][8][15:0];
        return r;
    endfunction

    // Filler words carry an unused opcode and their own address
    function automatic ccu_pkg::isa_word_t read_word(input ccu_pkg::addr_t a);
        if (a >= START && a < START + DEPTH) begin
            return mem[a - START];
        end
        return {{15{a}}, 16'heeff};
    endfunction

    task automatic build_buffer();
        int pos;
        int lo;
        pos = 0;
        for (int a = 0; a < DEPTH; a++) begin
            mem[a] = {{15{START + 16'(a)}}, 16'heeff};
        end
        for (int i = 0; i < NUM_ENT; i++) begin
            ord[i] = n_exp[tbl_op[i]];
            idx_of[tbl_op[i]][n_exp[tbl_op[i]]] = i;
            n_exp[tbl_op[i]]++;
            put_entry(pos, i);
            pos += words_of(tbl_op[i]);
            end_pos[tbl_op[i]] = pos;       // Pointer rests just past this word
        end
        lo = end_pos[0];
        for (int m = 1; m < 4; m++) begin
            if (end_pos[m] < lo) begin
                lo = end_pos[m];
            end
        end
        exp_min = START + 16'(lo);
        limit   = 40 * pos;
    endtask

    // Second SYA waits until FPS and KNN are through
    function automatic logic want(input int m);
        if (cnt[m] >= n_exp[m]) begin
            return 1'b0;
        end
        if (m == 3 && cnt[3] + 1 == n_exp[3]) begin
            return cnt[1] == n_exp[1] && cnt[2] == n_exp[2];
        end
        return 1'b1;
    endfunction

    // ======================================================================
    // Module ready drivers and buffer model
    // ======================================================================
    always @(posedge clk) begin
        if (run) begin
            fps_rdy <= want(1) && ($urandom % 4 != 0);
            knn_rdy <= want(2) && ($urandom % 4 != 0);
            sya_rdy <= want(3) && ($urandom % 4 != 0);
        end
    end

    always @(negedge clk) begin
        a_hs_s = rd_addr_vld && rd_addr_rdy;
        a_s    = rd_addr;
        d_hs_s = rd_dat_vld && rd_dat_rdy;
    end

    always @(posedge clk) begin
        if (run) begin
            rd_addr_rdy <= ($urandom % 2) == 0;
            if (a_hs_s) begin
                busy     <= 1'b1;
                buf_addr <= a_s;
                wait_cnt <= $urandom % 3;       // Data after 1 to 3 cycles
            end else if (busy && !rd_dat_vld) begin
                if (wait_cnt == 0) begin
                    rd_dat_vld <= 1'b1;
                    rd_dat     <= read_word(buf_addr);
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end
            if (d_hs_s) begin
                rd_dat_vld <= 1'b0;
                busy       <= 1'b0;
            end
        end
    end

    // ======================================================================
    // Checks
    // ======================================================================
    always @(negedge clk) begin
        if (rst_n) begin
            if (p_fps_vld && !p_fps_rdy) begin
                assert (fps_vld && fps_cfg == p_fps_cfg)
                    else report_error("FPS slot changed while stalled");
            end
            if (p_knn_vld && !p_knn_rdy) begin
                assert (knn_vld && knn_cfg == p_knn_cfg)
                    else report_error("KNN slot changed while stalled");
            end
            if (p_sya_vld && !p_sya_rdy) begin
                assert (sya_vld && sya_cfg == p_sya_cfg)
                    else report_error("SYA slot changed while stalled");
            end
            assert (net_fnh == sya_fin)
                else report_error("net_fnh_o not right after last SYA");
            if (p_fnh) begin
                assert (!net_fnh && mdu_rst)
                    else report_error("no return to idle after finish");
            end
            if (net_fnh) begin
                assert (rd_addr_min == exp_min)
                    else report_error("wrong lowest read pointer");
                fnh_cnt++;
            end
            sya_fin = 1'b0;
            if (fps_vld) begin
                assert (cnt[1] < n_exp[1]) else report_error("extra FPS configuration");
            end
            if (fps_vld && fps_rdy) begin
                assert (fps_cfg == exp_fps(idx_of[1][cnt[1]]))
                    else report_error("FPS payload mismatch");
                cnt[1]++;
            end
            if (knn_vld) begin
                assert (cnt[2] < n_exp[2]) else report_error("extra KNN configuration");
            end
            if (knn_vld && knn_rdy) begin
                assert (knn_cfg == exp_knn(idx_of[2][cnt[2]]))
                    else report_error("KNN payload mismatch");
                cnt[2]++;
            end
            if (sya_vld) begin
                assert (cnt[3] < n_exp[3]) else report_error("extra SYA configuration");
            end
            if (sya_vld && sya_rdy) begin
                assert (sya_cfg == exp_sya(idx_of[3][cnt[3]]))
                    else report_error("SYA payload mismatch");
                cnt[3]++;
                sya_fin = cnt[3] == n_exp[3];
            end
            p_fnh     = net_fnh;
            p_fps_vld = fps_vld;
            p_fps_rdy = fps_rdy;
            p_fps_cfg = fps_cfg;
            p_knn_vld = knn_vld;
            p_knn_rdy = knn_rdy;
            p_knn_cfg = knn_cfg;
            p_sya_vld = sya_vld;
            p_sya_rdy = sya_rdy;
            p_sya_cfg = sya_cfg;
        end
    end

    always @(posedge clk) begin
        if (run) begin
            cycles++;
            if (cycles > limit) begin
                $display("Timeout: the configuration sequence did not finish in %0d cycles",
                         limit);
                $display("Result: FAILED");
                $fatal(1, "Run stopped by the cycle limit");
            end
        end
    end

    // ======================================================================
    // Main sequence
    // ======================================================================
    initial begin
        void'($urandom(32'h35f2ecac));
        rst_n       = 1'b0;
        start_i     = 1'b0;
        run         = 1'b0;
        rd_addr_rdy = 1'b0;
        rd_dat      = '0;
        rd_dat_vld  = 1'b0;
        fps_rdy     = 1'b0;
        knn_rdy     = 1'b0;
        sya_rdy     = 1'b0;
        busy        = 1'b0;
        wait_cnt    = 0;
        a_hs_s      = 1'b0;
        d_hs_s      = 1'b0;
        sya_fin     = 1'b0;
        p_fnh       = 1'b0;
        fnh_cnt     = 0;
        cycles      = 0;
        p_fps_vld   = 1'b0;
        p_knn_vld   = 1'b0;
        p_sya_vld   = 1'b0;
        for (int m = 0; m < 4; m++) begin
            n_exp[m] = 0;
            cnt[m]   = 0;
        end
        fill_table();
        build_buffer();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        assert (!fps_vld && !knn_vld && !sya_vld && !rd_addr_vld && !net_fnh && mdu_rst)
            else report_error("outputs wrong after reset");
        @(posedge clk);
        start_i <= 1'b1;
        run     <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
        // Each table step ends when its configuration is taken
        for (int i = 0; i < NUM_ENT; i++) begin
            if (tbl_op[i] != 2'd0) begin
                while (cnt[tbl_op[i]] <= ord[i]) @(posedge clk);
            end
        end
        while (fnh_cnt == 0) @(posedge clk);
        @(posedge clk);
        $display("Result: PASSED");
        $finish;
    end

endmodule
